//--- hdl/mcb_cfg.svh
`ifndef MCB_CFG_SVH
`define MCB_CFG_SVH

// processor address and data width
`define MCB_ADDR_W 32

// byte lanes in one data word
`define MCB_MASK_W (`MCB_ADDR_W/8)

// outstanding transactions, tag width follows
`define MCB_TAGS 4
`define MCB_TAG_W $clog2(`MCB_TAGS)

// network credits after reset
`define MCB_CREDITS 4

// mesh geometry
`define MCB_COORD_W 4
`define MCB_PKT_ADDR_W 18
// bottom cache row is one below the last tile row
`define MCB_TILES_Y 4

`endif

//--- hdl/mcb_pkg.sv
package mcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // processor side
  //////////////////////////////////////////////////////////////////////

  // uncached command kind
  typedef enum logic [0:0]
  {
    cmd_load  = 1'b0
    , cmd_store = 1'b1
  } cmd_type_e;

  // access size in bytes
  typedef enum logic [1:0]
  {
    size_1 = 2'b00
    , size_2 = 2'b01
    , size_4 = 2'b10
  } cmd_size_e;

  //////////////////////////////////////////////////////////////////////
  // mesh side
  //////////////////////////////////////////////////////////////////////

  // packet opcode
  typedef enum logic [0:0]
  {
    op_load  = 1'b0
    , op_store = 1'b1
  } net_op_e;

endpackage

//--- hdl/mcb_cmd_fifo.sv
`timescale 1ns/1ps
`include "mcb_cfg.svh"

module mcb_cmd_fifo
  (input                                clk_i
   , input                              reset_i

   , input                              cmd_v_i
   , output logic                       cmd_ready_o
   , input mcb_pkg::cmd_type_e          cmd_type_i
   , input mcb_pkg::cmd_size_e          cmd_size_i
   , input [`MCB_ADDR_W-1:0]            cmd_addr_i
   , input [`MCB_ADDR_W-1:0]            cmd_data_i

   , output logic                       head_v_o
   , input                              head_yumi_i
   , output mcb_pkg::cmd_type_e         head_type_o
   , output mcb_pkg::cmd_size_e         head_size_o
   , output logic [`MCB_ADDR_W-1:0]     head_addr_o
   , output logic [`MCB_ADDR_W-1:0]     head_data_o
   );

  import mcb_pkg::*;

  // two slots of command storage
  cmd_type_e              type_mem [2];
  cmd_size_e              size_mem [2];
  logic [`MCB_ADDR_W-1:0] addr_mem [2];
  logic [`MCB_ADDR_W-1:0] data_mem [2];

  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  assign cmd_ready_o = (count_r != 2'd2);
  assign head_v_o    = (count_r != 2'd0);
  assign push        = cmd_v_i & cmd_ready_o;
  assign pop         = head_yumi_i & head_v_o;

  always_ff @(posedge clk_i)
    begin
      if (push)
        begin
          type_mem[wr_ptr_r] <= cmd_type_i;
          size_mem[wr_ptr_r] <= cmd_size_i;
          addr_mem[wr_ptr_r] <= cmd_addr_i;
          data_mem[wr_ptr_r] <= cmd_data_i;
        end
    end

  // pointers wrap naturally at two entries
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          wr_ptr_r <= 1'b0;
          rd_ptr_r <= 1'b0;
          count_r  <= 2'd0;
        end
      else
        begin
          if (push)
            wr_ptr_r <= ~wr_ptr_r;
          if (pop)
            rd_ptr_r <= ~rd_ptr_r;
          if (push & ~pop)
            count_r <= count_r + 2'd1;
          else if (pop & ~push)
            count_r <= count_r - 2'd1;
        end
    end

  // oldest command
  assign head_type_o = type_mem[rd_ptr_r];
  assign head_size_o = size_mem[rd_ptr_r];
  assign head_addr_o = addr_mem[rd_ptr_r];
  assign head_data_o = data_mem[rd_ptr_r];

endmodule

//--- hdl/mcb_request_issue.sv
`timescale 1ns/1ps
`include "mcb_cfg.svh"

module mcb_request_issue
  (input                                clk_i
   , input                              reset_i

   , input                              head_v_i
   , output logic                       head_yumi_o
   , input mcb_pkg::cmd_type_e          head_type_i
   , input mcb_pkg::cmd_size_e          head_size_i
   , input [`MCB_ADDR_W-1:0]            head_addr_i
   , input [`MCB_ADDR_W-1:0]            head_data_i

   , input                              alloc_v_i
   , input [`MCB_TAG_W-1:0]             alloc_tag_i
   , output logic                       alloc_yumi_o

   , input                              credit_i

   , output logic                       pkt_v_o
   , output mcb_pkg::net_op_e           pkt_op_o
   , output logic [`MCB_COORD_W-1:0]    pkt_x_o
   , output logic [`MCB_COORD_W-1:0]    pkt_y_o
   , output logic [`MCB_PKT_ADDR_W-1:0] pkt_addr_o
   , output logic [`MCB_ADDR_W-1:0]     pkt_data_o
   , output logic [`MCB_MASK_W-1:0]     pkt_mask_o
   , output logic [`MCB_TAG_W-1:0]      pkt_tag_o
   );

  import mcb_pkg::*;

  localparam int coord_w    = `MCB_COORD_W;
  localparam int pkt_addr_w = `MCB_PKT_ADDR_W;
  localparam int mask_w     = `MCB_MASK_W;
  localparam int credit_w   = $clog2(`MCB_CREDITS + 1);

  logic [credit_w-1:0] credit_cnt_r;
  logic                issue;
  logic                remote;
  logic [2:0]          bank;
  logic [mask_w-1:0]   base_mask;

  //////////////////////////////////////////////////////////////////////
  // destination mapping
  //////////////////////////////////////////////////////////////////////

  assign remote = head_addr_i[`MCB_ADDR_W-1];
  // {bottom row, x} of the cache bank
  assign bank   = head_addr_i[7:5];

  always_comb
    begin
      if (~remote)
        begin
          pkt_y_o    = head_addr_i[27:24];
          pkt_x_o    = head_addr_i[23:20];
          pkt_addr_o = head_addr_i[19:2];
        end
      else
        begin
          // cache banks sit above and below the tile array
          pkt_y_o    = bank[2] ? coord_w'(`MCB_TILES_Y + 1) : '0;
          pkt_x_o    = coord_w'(bank[1:0]);
          pkt_addr_o = pkt_addr_w'({head_addr_i[17:8], head_addr_i[4:2]});
        end
    end

  //////////////////////////////////////////////////////////////////////
  // store mask and opcode
  //////////////////////////////////////////////////////////////////////

  always_comb
    begin
      case (head_size_i)
        size_1:  base_mask = mask_w'(4'h1);
        size_2:  base_mask = mask_w'(4'h3);
        default: base_mask = mask_w'(4'hf);
      endcase
    end

  assign pkt_mask_o = (head_type_i == cmd_store) ? (base_mask << head_addr_i[1:0]) : '0;
  assign pkt_op_o   = (head_type_i == cmd_store) ? op_store : op_load;
  assign pkt_data_o = head_data_i;
  assign pkt_tag_o  = alloc_tag_i;

  //////////////////////////////////////////////////////////////////////
  // credits and issue
  //////////////////////////////////////////////////////////////////////

  // head, tag and credit all present
  assign issue        = head_v_i & alloc_v_i & (credit_cnt_r != '0);
  assign head_yumi_o  = issue;
  assign alloc_yumi_o = issue;
  assign pkt_v_o      = issue;

  // issue and credit return in one cycle cancel out
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        credit_cnt_r <= credit_w'(`MCB_CREDITS);
      else if (issue & ~credit_i)
        credit_cnt_r <= credit_cnt_r - 1'b1;
      else if (credit_i & ~issue)
        credit_cnt_r <= credit_cnt_r + 1'b1;
    end

endmodule

//--- hdl/mcb_reorder_buf.sv
`timescale 1ns/1ps
`include "mcb_cfg.svh"

module mcb_reorder_buf
  (input                                clk_i
   , input                              reset_i

   , output logic                       alloc_v_o
   , output logic [`MCB_TAG_W-1:0]      alloc_tag_o
   , input                              alloc_yumi_i
   , input mcb_pkg::cmd_type_e          alloc_type_i
   , input mcb_pkg::cmd_size_e          alloc_size_i
   , input [`MCB_ADDR_W-1:0]            alloc_addr_i

   , input                              ret_v_i
   , input [`MCB_TAG_W-1:0]             ret_tag_i
   , input [`MCB_ADDR_W-1:0]            ret_data_i

   , output logic                       resp_v_o
   , input                              resp_yumi_i
   , output mcb_pkg::cmd_type_e         resp_type_o
   , output mcb_pkg::cmd_size_e         resp_size_o
   , output logic [`MCB_ADDR_W-1:0]     resp_addr_o
   , output logic [`MCB_ADDR_W-1:0]     resp_data_o
   );

  import mcb_pkg::*;

  localparam int               tag_w    = `MCB_TAG_W;
  localparam logic [tag_w-1:0] last_tag = tag_w'(`MCB_TAGS - 1);

  // saved command fields and returned data, one entry per tag
  cmd_type_e              type_mem [`MCB_TAGS];
  cmd_size_e              size_mem [`MCB_TAGS];
  logic [`MCB_ADDR_W-1:0] addr_mem [`MCB_TAGS];
  logic [`MCB_ADDR_W-1:0] data_mem [`MCB_TAGS];

  logic [`MCB_TAGS-1:0] busy_r;
  logic [`MCB_TAGS-1:0] done_r;
  logic [tag_w-1:0]     tail_r;
  logic [tag_w-1:0]     head_r;
  logic                 release_v;

  assign alloc_v_o   = ~busy_r[tail_r];
  assign alloc_tag_o = tail_r;

  // oldest tag leaves only once its return is in
  assign resp_v_o  = busy_r[head_r] & done_r[head_r];
  assign release_v = resp_v_o & resp_yumi_i;

  always_ff @(posedge clk_i)
    begin
      if (alloc_yumi_i)
        begin
          type_mem[tail_r] <= alloc_type_i;
          size_mem[tail_r] <= alloc_size_i;
          addr_mem[tail_r] <= alloc_addr_i;
        end
      if (ret_v_i)
        data_mem[ret_tag_i] <= ret_data_i;
    end

  //////////////////////////////////////////////////////////////////////
  // tag state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          busy_r <= '0;
          done_r <= '0;
          tail_r <= '0;
          head_r <= '0;
        end
      else
        begin
          if (alloc_yumi_i)
            begin
              busy_r[tail_r] <= 1'b1;
              done_r[tail_r] <= 1'b0;
              tail_r         <= (tail_r == last_tag) ? '0 : tail_r + 1'b1;
            end
          // returns can land on any outstanding tag
          if (ret_v_i)
            done_r[ret_tag_i] <= 1'b1;
          if (release_v)
            begin
              busy_r[head_r] <= 1'b0;
              head_r         <= (head_r == last_tag) ? '0 : head_r + 1'b1;
            end
        end
    end

  assign resp_type_o = type_mem[head_r];
  assign resp_size_o = size_mem[head_r];
  assign resp_addr_o = addr_mem[head_r];
  // stores answer with zero data
  assign resp_data_o = (type_mem[head_r] == cmd_load) ? data_mem[head_r] : '0;

endmodule

//--- hdl/mcb_bridge.sv
`timescale 1ns/1ps
`include "mcb_cfg.svh"

module mcb_bridge
  (input                                clk_i
   , input                              reset_i

   , input                              cmd_v_i
   , output logic                       cmd_ready_o
   , input mcb_pkg::cmd_type_e          cmd_type_i
   , input mcb_pkg::cmd_size_e          cmd_size_i
   , input [`MCB_ADDR_W-1:0]            cmd_addr_i
   , input [`MCB_ADDR_W-1:0]            cmd_data_i

   , output logic                       pkt_v_o
   , output mcb_pkg::net_op_e           pkt_op_o
   , output logic [`MCB_COORD_W-1:0]    pkt_x_o
   , output logic [`MCB_COORD_W-1:0]    pkt_y_o
   , output logic [`MCB_PKT_ADDR_W-1:0] pkt_addr_o
   , output logic [`MCB_ADDR_W-1:0]     pkt_data_o
   , output logic [`MCB_MASK_W-1:0]     pkt_mask_o
   , output logic [`MCB_TAG_W-1:0]      pkt_tag_o
   , input                              credit_i

   , input                              ret_v_i
   , input [`MCB_TAG_W-1:0]             ret_tag_i
   , input [`MCB_ADDR_W-1:0]            ret_data_i

   , output logic                       resp_v_o
   , input                              resp_yumi_i
   , output mcb_pkg::cmd_type_e         resp_type_o
   , output mcb_pkg::cmd_size_e         resp_size_o
   , output logic [`MCB_ADDR_W-1:0]     resp_addr_o
   , output logic [`MCB_ADDR_W-1:0]     resp_data_o
   );

  import mcb_pkg::*;

  // fifo head
  logic                   head_v;
  logic                   head_yumi;
  cmd_type_e              head_type;
  cmd_size_e              head_size;
  logic [`MCB_ADDR_W-1:0] head_addr;
  logic [`MCB_ADDR_W-1:0] head_data;

  // tag allocation
  logic                   alloc_v;
  logic [`MCB_TAG_W-1:0]  alloc_tag;
  logic                   alloc_yumi;

  mcb_cmd_fifo fifo0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.cmd_type_i(cmd_type_i)
     ,.cmd_size_i(cmd_size_i)
     ,.cmd_addr_i(cmd_addr_i)
     ,.cmd_data_i(cmd_data_i)
     ,.head_v_o(head_v)
     ,.head_yumi_i(head_yumi)
     ,.head_type_o(head_type)
     ,.head_size_o(head_size)
     ,.head_addr_o(head_addr)
     ,.head_data_o(head_data)
     );

  mcb_request_issue issue0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.head_v_i(head_v)
     ,.head_yumi_o(head_yumi)
     ,.head_type_i(head_type)
     ,.head_size_i(head_size)
     ,.head_addr_i(head_addr)
     ,.head_data_i(head_data)
     ,.alloc_v_i(alloc_v)
     ,.alloc_tag_i(alloc_tag)
     ,.alloc_yumi_o(alloc_yumi)
     ,.credit_i(credit_i)
     ,.pkt_v_o(pkt_v_o)
     ,.pkt_op_o(pkt_op_o)
     ,.pkt_x_o(pkt_x_o)
     ,.pkt_y_o(pkt_y_o)
     ,.pkt_addr_o(pkt_addr_o)
     ,.pkt_data_o(pkt_data_o)
     ,.pkt_mask_o(pkt_mask_o)
     ,.pkt_tag_o(pkt_tag_o)
     );

  mcb_reorder_buf rob0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.alloc_v_o(alloc_v)
     ,.alloc_tag_o(alloc_tag)
     ,.alloc_yumi_i(alloc_yumi)
     ,.alloc_type_i(head_type)
     ,.alloc_size_i(head_size)
     ,.alloc_addr_i(head_addr)
     ,.ret_v_i(ret_v_i)
     ,.ret_tag_i(ret_tag_i)
     ,.ret_data_i(ret_data_i)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     ,.resp_type_o(resp_type_o)
     ,.resp_size_o(resp_size_o)
     ,.resp_addr_o(resp_addr_o)
     ,.resp_data_o(resp_data_o)
     );

endmodule

//--- bench/mcb_chk.sv
`timescale 1ns/1ps
`include "mcb_cfg.svh"

module mcb_chk
  (input                              clk_i
   , input                            reset_i
   , input                            pkt_v_i
   , input mcb_pkg::net_op_e          pkt_op_i
   , input [`MCB_MASK_W-1:0]          pkt_mask_i
   , input                            credit_i
   , input                            resp_v_i
   , input                            resp_yumi_i
   , input mcb_pkg::cmd_type_e        resp_type_i
   , input mcb_pkg::cmd_size_e        resp_size_i
   , input [`MCB_ADDR_W-1:0]          resp_addr_i
   , input [`MCB_ADDR_W-1:0]          resp_data_i
   );

  import mcb_pkg::*;

  localparam int credit_w = $clog2(`MCB_CREDITS + 1);

  // credit count as seen from the ports
  logic [credit_w-1:0] credits_r;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        credits_r <= credit_w'(`MCB_CREDITS);
      else if (pkt_v_i & ~credit_i)
        credits_r <= credits_r - credit_w'(1);
      else if (credit_i & ~pkt_v_i)
        credits_r <= credits_r + credit_w'(1);
    end

  pkt_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_v_i |-> (credits_r != '0))
    else $error("packet sent with no network credit left");

  // response waits unchanged until taken
  resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_i & ~resp_yumi_i) |=> (resp_v_i && $stable(resp_type_i)
      && $stable(resp_size_i) && $stable(resp_addr_i) && $stable(resp_data_i)))
    else $error("response changed or dropped before it was taken");

  store_has_mask: assert property (@(posedge clk_i) disable iff (reset_i)
    (pkt_v_i && pkt_op_i == op_store) |-> (pkt_mask_i != '0))
    else $error("store packet with an empty byte mask");

endmodule

bind mcb_bridge mcb_chk chk0
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.pkt_v_i(pkt_v_o)
   ,.pkt_op_i(pkt_op_o)
   ,.pkt_mask_i(pkt_mask_o)
   ,.credit_i(credit_i)
   ,.resp_v_i(resp_v_o)
   ,.resp_yumi_i(resp_yumi_i)
   ,.resp_type_i(resp_type_o)
   ,.resp_size_i(resp_size_o)
   ,.resp_addr_i(resp_addr_o)
   ,.resp_data_i(resp_data_o)
   );

//--- bench/mcb_tb.sv
`timescale 1ns/1ps
`include "mcb_cfg.svh"

module mcb_tb;

  import mcb_pkg::*;

  localparam int num_cmds       = 18;
  localparam int row_w          = 104;
  localparam int timeout_cycles = 400;

  // {type, size, address, store data, x, y, packet address, mask}
  // type and size take one hex digit each, packet address five
  localparam logic [row_w-1:0] cmd_table [num_cmds] = '{
    104'h0_2_03123454_00000000_1_3_08D15_0,
    104'h1_2_02356788_DEADBEEF_3_2_159E2_F,
    104'h0_2_800012E4_00000000_3_5_00091_0,
    104'h1_2_80034A48_12345678_2_0_01A52_F,
    104'h0_1_80000090_00000000_0_5_00004_0,
    104'h0_0_0F0FFFFF_00000000_0_F_3FFFF_0,
    104'h1_0_01100100_C0DE0007_1_1_00040_1,
    104'h1_0_01100101_C0DE0008_1_1_00040_2,
    104'h1_0_01100102_C0DE0009_1_1_00040_4,
    104'h1_0_01100103_C0DE000A_1_1_00040_8,
    104'h1_1_01100100_C0DE000B_1_1_00040_3,
    104'h1_1_01100101_C0DE000C_1_1_00040_6,
    104'h1_1_01100102_C0DE000D_1_1_00040_C,
    104'h1_1_01100103_C0DE000E_1_1_00040_8,
    104'h1_2_01100100_C0DE000F_1_1_00040_F,
    104'h1_2_01100101_C0DE0010_1_1_00040_E,
    104'h1_2_01100102_C0DE0011_1_1_00040_C,
    104'h1_2_01100103_C0DE0012_1_1_00040_8
  };

  logic                       clk_i;
  logic                       reset_i;
  logic                       cmd_v_i;
  logic                       cmd_ready_o;
  cmd_type_e                  cmd_type_i;
  cmd_size_e                  cmd_size_i;
  logic [`MCB_ADDR_W-1:0]     cmd_addr_i;
  logic [`MCB_ADDR_W-1:0]     cmd_data_i;
  logic                       pkt_v_o;
  net_op_e                    pkt_op_o;
  logic [`MCB_COORD_W-1:0]    pkt_x_o;
  logic [`MCB_COORD_W-1:0]    pkt_y_o;
  logic [`MCB_PKT_ADDR_W-1:0] pkt_addr_o;
  logic [`MCB_ADDR_W-1:0]     pkt_data_o;
  logic [`MCB_MASK_W-1:0]     pkt_mask_o;
  logic [`MCB_TAG_W-1:0]      pkt_tag_o;
  logic                       credit_i;
  logic                       ret_v_i;
  logic [`MCB_TAG_W-1:0]      ret_tag_i;
  logic [`MCB_ADDR_W-1:0]     ret_data_i;
  logic                       resp_v_o;
  logic                       resp_yumi_i;
  cmd_type_e                  resp_type_o;
  cmd_size_e                  resp_size_o;
  logic [`MCB_ADDR_W-1:0]     resp_addr_o;
  logic [`MCB_ADDR_W-1:0]     resp_data_o;

  int errors   = 0;
  int timeouts = 0;
  int pkt_cnt  = 0;
  int resp_cnt = 0;

  // credits the network still holds back from the bridge
  int credits_owed = 0;

  // packets still out on the network
  logic [`MCB_TAG_W-1:0]      tag_q [$];
  logic [`MCB_PKT_ADDR_W-1:0] paddr_q [$];

  mcb_bridge dut0 (.*);

  initial
    begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else
        begin
          errors++;
          $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
  endtask

  function automatic bit tag_outstanding(input logic [`MCB_TAG_W-1:0] tag);
    foreach (tag_q[j])
      if (tag_q[j] == tag)
        return 1'b1;
    return 1'b0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // network model
  //////////////////////////////////////////////////////////////////////

  task automatic check_packet();
    logic [row_w-1:0] row;
    net_op_e          exp_op;
    assert (pkt_cnt < num_cmds)
      else
        begin
          errors++;
          $display("packet beyond the last command at %0t", $time);
        end
    assert (!tag_outstanding(pkt_tag_o))
      else
        begin
          errors++;
          $display("tag %0d sent again before its return at %0t", pkt_tag_o, $time);
        end
    if (pkt_cnt < num_cmds)
      begin
        row    = cmd_table[pkt_cnt];
        exp_op = row[100] ? op_store : op_load;
        check_value("pkt_op_o", 32'(pkt_op_o), 32'(exp_op));
        check_value("pkt_x_o", 32'(pkt_x_o), 32'(row[31:28]));
        check_value("pkt_y_o", 32'(pkt_y_o), 32'(row[27:24]));
        check_value("pkt_addr_o", 32'(pkt_addr_o), 32'(row[21:4]));
        check_value("pkt_mask_o", 32'(pkt_mask_o), 32'(row[3:0]));
        if (row[100])
          check_value("pkt_data_o", pkt_data_o, row[63:32]);
      end
  endtask

  always @(posedge clk_i)
    begin
      int k;
      ret_v_i  <= 1'b0;
      credit_i <= 1'b0;
      if (!reset_i && pkt_v_o)
        begin
          check_packet();
          tag_q.push_back(pkt_tag_o);
          paddr_q.push_back(pkt_addr_o);
          pkt_cnt++;
        end
      // returns trickle back in random order
      if (!reset_i && tag_q.size() > 0 && $urandom_range(2) == 0)
        begin
          k = $urandom_range(tag_q.size() - 1);
          ret_v_i    <= 1'b1;
          ret_tag_i  <= tag_q[k];
          ret_data_i <= 32'(paddr_q[k]) ^ 32'hA5A50000;
          tag_q.delete(k);
          paddr_q.delete(k);
          credits_owed++;
        end
      // credits lag behind the returns, so the bridge runs dry with free tags
      if (!reset_i && credits_owed > 0 && $urandom_range(3) == 0)
        begin
          credit_i <= 1'b1;
          credits_owed--;
        end
    end

  //////////////////////////////////////////////////////////////////////
  // processor response side
  //////////////////////////////////////////////////////////////////////

  task automatic check_response();
    logic [row_w-1:0] row;
    logic [31:0]      exp_data;
    assert (resp_cnt < num_cmds)
      else
        begin
          errors++;
          $display("response beyond the last command at %0t", $time);
        end
    if (resp_cnt < num_cmds)
      begin
        row = cmd_table[resp_cnt];
        // loads see the packet address folded with a fixed pattern
        exp_data = row[100] ? 32'h0 : (32'(row[21:4]) ^ 32'hA5A50000);
        check_value("resp_type_o", 32'(resp_type_o), 32'(row[100]));
        check_value("resp_size_o", 32'(resp_size_o), 32'(row[97:96]));
        check_value("resp_addr_o", resp_addr_o, row[95:64]);
        check_value("resp_data_o", resp_data_o, exp_data);
      end
  endtask

  always @(posedge clk_i)
    begin
      resp_yumi_i <= ($urandom_range(3) != 0);
      if (!reset_i && resp_v_o && resp_yumi_i)
        begin
          check_response();
          resp_cnt++;
        end
    end

  //////////////////////////////////////////////////////////////////////
  // command stream
  //////////////////////////////////////////////////////////////////////

  initial
    begin
      int wait_cnt;
      void'($urandom(60));
      reset_i     = 1'b1;
      cmd_v_i     = 1'b0;
      cmd_type_i  = cmd_load;
      cmd_size_i  = size_1;
      cmd_addr_i  = '0;
      cmd_data_i  = '0;
      credit_i    = 1'b0;
      ret_v_i     = 1'b0;
      ret_tag_i   = '0;
      ret_data_i  = '0;
      resp_yumi_i = 1'b0;
      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;
      for (int i = 0; i < num_cmds; i++)
        begin
          cmd_v_i    <= 1'b1;
          cmd_type_i <= cmd_type_e'(cmd_table[i][100]);
          cmd_size_i <= cmd_size_e'(cmd_table[i][97:96]);
          cmd_addr_i <= cmd_table[i][95:64];
          cmd_data_i <= cmd_table[i][63:32];
          wait_cnt = 0;
          do
            begin
              @(posedge clk_i);
              wait_cnt++;
            end
          while (!cmd_ready_o && wait_cnt < timeout_cycles);
          if (!cmd_ready_o)
            begin
              $display("timeout: command %0d was never accepted", i);
              timeouts++;
              break;
            end
        end
      cmd_v_i <= 1'b0;
      wait_cnt = 0;
      while (timeouts == 0 && resp_cnt < num_cmds && wait_cnt < timeout_cycles)
        begin
          @(posedge clk_i);
          wait_cnt++;
        end
      if (timeouts == 0 && resp_cnt < num_cmds)
        begin
          $display("timeout: only %0d of %0d responses came back", resp_cnt, num_cmds);
          timeouts++;
        end
      assert (pkt_cnt == num_cmds)
        else
          begin
            errors++;
            $display("%0d packets were sent for %0d commands", pkt_cnt, num_cmds);
          end
      $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
        $display("RESULT: PASS");
      else
        $display("RESULT: FAIL");
      $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/mcb_pkg.sv
hdl/mcb_cmd_fifo.sv
hdl/mcb_request_issue.sv
hdl/mcb_reorder_buf.sv
hdl/mcb_bridge.sv
bench/mcb_chk.sv
bench/mcb_tb.sv

//--- Makefile
# Verilator flow for the memory command bridge

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mcb_tb \
		-f build.f -o mcb_sim
	./obj_dir/mcb_sim | tee sim.log
	@if grep -qx "RESULT: PASS" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
